//--- draw_line.sv
// Bresenham line engine, walks p0 down to p1 and strobes each point once
`timescale 1ns/1ps

module draw_line (
    input  logic   clk,
    input  logic   reset_i,
    line_if.engine lif
);

    typedef enum logic [2:0] {
        IDLE,
        INIT_0,
        INIT_1,
        PLOT,                                     // point offered, waits for oe
        DECIDE,
        STEP
    } state_t;

    state_t           state;
    logic             right;                      // x grows along the line
    geom_pkg::err_t   err;                        // running Bresenham error
    geom_pkg::err_t   dx;                         // abs(x1 - x0)
    geom_pkg::err_t   dy;                         // y0 - y1, never positive
    logic             movx;                       // step in x this round
    logic             movy;                       // step in y this round
    geom_pkg::point_t pos;                        // current point
    logic             busy_q;
    logic             done_q;
    logic             at_end;

    assign lif.pix     = pos;
    assign lif.busy    = busy_q;
    assign lif.done    = done_q;
    assign lif.pix_stb = (state == PLOT) && lif.oe; // plot state left at once, so one strobe
    assign at_end      = (pos.x == lif.p1.x) && (pos.y == lif.p1.y);

    always_ff @(posedge clk) begin
        if (reset_i) begin
            state  <= IDLE;
            busy_q <= 1'b0;
            done_q <= 1'b0;
        end else begin
            done_q <= 1'b0;                       // pulse only
            case (state)
                IDLE: begin
                    if (lif.start) begin
                        state  <= INIT_0;
                        right  <= (lif.p0.x < lif.p1.x);
                        busy_q <= 1'b1;
                    end
                end
                INIT_0: begin
                    state <= INIT_1;
                    dx    <= right ? lif.p1.x - lif.p0.x : lif.p0.x - lif.p1.x;
                    dy    <= lif.p0.y - lif.p1.y;
                end
                INIT_1: begin
                    state <= PLOT;
                    err   <= dx + dy;
                    pos   <= lif.p0;
                end
                PLOT: begin
                    if (lif.oe) begin             // point handed over now
                        if (at_end) begin
                            state  <= IDLE;
                            busy_q <= 1'b0;
                            done_q <= 1'b1;
                        end else begin
                            state <= DECIDE;
                        end
                    end
                end
                DECIDE: begin
                    state <= STEP;
                    movx  <= (2 * err >= dy);
                    movy  <= (2 * err <= dx);
                end
                STEP: begin
                    state <= PLOT;
                    if (movx) begin
                        pos.x <= right ? pos.x + 1'b1 : pos.x - 1'b1;
                    end
                    if (movy) begin
                        pos.y <= pos.y + 1'b1;    // always down
                    end
                    // both corrections apply on a diagonal step
                    err <= err + (movx ? dy : '0) + (movy ? dx : '0);
                end
                default: begin
                    state <= IDLE;
                end
            endcase
        end
    end

endmodule

//--- geom_pkg.sv
// geometry package: framebuffer coordinate, error-term and vertex types
package geom_pkg;

    localparam int CORDW = 10;                    // framebuffer coordinate width in bits

    // signed so that differences and directions come out naturally
    typedef logic signed [CORDW-1:0] coord_t;

    // one extra bit keeps dx + dy and the running error in range
    typedef logic signed [CORDW:0] err_t;

    // a vertex or a drawn point
    typedef struct packed {
        coord_t x;                                // column
        coord_t y;                                // row, grows downward
    } point_t;

endpackage

//--- line_if.sv
// link between one line engine and the pixel merger
`timescale 1ns/1ps

interface line_if;

    logic              start;                     // command strobe
    geom_pkg::point_t  p0;                        // line start, the top vertex
    geom_pkg::point_t  p1;                        // line end
    logic              oe;                        // engine may hand over a point
    geom_pkg::point_t  pix;                       // point being handed over
    logic              pix_stb;                   // point accepted this cycle
    logic              busy;                      // line in progress
    logic              done;                      // line finished, one cycle

    modport engine (
        input  start,
        input  p0,
        input  p1,
        input  oe,
        output pix,
        output pix_stb,
        output busy,
        output done
    );

    modport merger (
        input  pix,
        input  pix_stb,
        input  busy,
        input  done,
        output oe
    );

endinterface

//--- list.f
geom_pkg.sv
render_pkg.sv
line_if.sv
draw_line.sv
pixel_merge.sv
tri_edges.sv
tri_edges_props.sv
tb_tri_edges.sv

//--- pixel_merge.sv
// pixel merger, interleaves two line engines into one stallable pixel stream
`timescale 1ns/1ps

module pixel_merge (
    input  logic                clk,
    input  logic                reset_i,
    input  logic                start_i,
    input  logic                stall_i,
    line_if.merger              ab,
    line_if.merger              ac,
    output geom_pkg::coord_t    px_o,
    output geom_pkg::coord_t    py_o,
    output render_pkg::eng_id_t psrc_o,
    output logic                pvalid_o,
    output logic                busy_o,
    output logic                done_o
);

    render_pkg::eng_id_t          grant;          // engine allowed to hand over
    logic [render_pkg::N_ENG-1:0] done_q;         // edges finished so far
    logic [render_pkg::N_ENG-1:0] done_seen;      // including this cycle's pulses
    logic                         cmd_start;

    assign cmd_start = start_i && !busy_o;        // new command only when idle

    // an idle engine gets no enable, a stall blocks both
    assign ab.oe = ab.busy && (grant == render_pkg::SRC_AB) && !stall_i;
    assign ac.oe = ac.busy && (grant == render_pkg::SRC_AC) && !stall_i;

    always_comb begin
        done_seen                     = done_q;
        done_seen[render_pkg::SRC_AB] = done_q[render_pkg::SRC_AB] | ab.done;
        done_seen[render_pkg::SRC_AC] = done_q[render_pkg::SRC_AC] | ac.done;
    end

    always_ff @(posedge clk) begin
        if (reset_i) begin
            grant    <= render_pkg::SRC_AB;
            pvalid_o <= 1'b0;
            busy_o   <= 1'b0;
            done_o   <= 1'b0;
            done_q   <= '0;
        end else begin
            grant    <= grant + 1'b1;             // toggles every cycle
            pvalid_o <= ab.pix_stb || ac.pix_stb;
            done_o   <= 1'b0;
            if (cmd_start) begin
                busy_o <= 1'b1;
                done_q <= '0;
            end else if (busy_o) begin
                done_q <= done_seen;
                if (&done_seen) begin             // second edge just finished
                    busy_o <= 1'b0;
                    done_o <= 1'b1;
                end
            end
        end
    end

    // payload, qualified by pvalid_o
    always_ff @(posedge clk) begin
        if (ab.pix_stb) begin
            px_o   <= ab.pix.x;
            py_o   <= ab.pix.y;
            psrc_o <= render_pkg::SRC_AB;
        end else if (ac.pix_stb) begin
            px_o   <= ac.pix.x;
            py_o   <= ac.pix.y;
            psrc_o <= render_pkg::SRC_AC;
        end
    end

endmodule

//--- render_pkg.sv
// render package: engine count, engine ids and pixel source codes
package render_pkg;

    localparam int N_ENG = 2;                     // one engine per upper edge

    // enough bits to name every engine
    typedef logic [$clog2(N_ENG)-1:0] eng_id_t;

    localparam eng_id_t SRC_AB = 1'b0;            // edge from top vertex to left vertex
    localparam eng_id_t SRC_AC = 1'b1;            // edge from top vertex to right vertex

endpackage

//--- tb_tri_edges.sv
// testbench for the triangle edge renderer, checks pixels against a line model
`timescale 1ns/1ps

module tb_tri_edges;

    localparam int MAX_CMD = 64;
    localparam int RESET_CYCLES = 8;

    logic                clk;
    logic                reset_i;
    logic                start_i;
    logic                stall_i;
    geom_pkg::coord_t    ax_i;
    geom_pkg::coord_t    ay_i;
    geom_pkg::coord_t    bx_i;
    geom_pkg::coord_t    by_i;
    geom_pkg::coord_t    cx_i;
    geom_pkg::coord_t    cy_i;
    geom_pkg::coord_t    px_o;
    geom_pkg::coord_t    py_o;
    render_pkg::eng_id_t psrc_o;
    logic                pvalid_o;
    logic                busy_o;
    logic                done_o;

    int          cmd_tab [0:MAX_CMD-1][0:8];  // ax ay bx by cx cy nab nac stall
    int          n_cmd;
    logic [19:0] exp_ab [$];                  // {x, y} still to come on edge AB
    logic [19:0] exp_ac [$];
    int          n_ab;                        // pixels seen in this command
    int          n_ac;
    int          done_total;
    int          done_want;
    int          cycle_cnt;
    int          cycle_limit;
    logic        stall_en;
    logic        stall_prev;

    tri_edges i_dut (.*);

    initial begin
        clk = 1'b0;
        forever #2 clk = ~clk;
    end

    task automatic stop_with_error(input string msg);
        $display("Something failed");
        $display("%s", msg);
        $fatal(1, "simulation stopped");
    endtask

    // reference Bresenham walk from p0 down to p1
    task automatic model_edge(input int x0, input int y0, input int x1, input int y1,
                              input bit to_ac);
        int x;
        int y;
        int dx;
        int dy;
        int sx;
        int err;
        int e2;
        bit last;
        x    = x0;
        y    = y0;
        dx   = (x1 > x0) ? x1 - x0 : x0 - x1;
        dy   = y0 - y1;                       // zero or negative
        sx   = (x0 < x1) ? 1 : -1;
        err  = dx + dy;
        last = 1'b0;
        while (!last) begin
            if (to_ac) exp_ac.push_back({x[9:0], y[9:0]});
            else exp_ab.push_back({x[9:0], y[9:0]});
            if (x == x1 && y == y1) begin
                last = 1'b1;
            end else begin
                e2 = 2 * err;
                if (e2 >= dy) begin
                    err = err + dy;
                    x   = x + sx;
                end
                if (e2 <= dx) begin
                    err = err + dx;
                    y   = y + 1;
                end
            end
        end
    endtask

    task automatic load_commands;
        int    fd;
        int    got;
        int    v [0:8];
        string line;
        fd = $fopen("tri_edges_stim.txt", "r");
        assert (fd != 0) else stop_with_error("cannot open tri_edges_stim.txt");
        n_cmd = 0;
        while ($fgets(line, fd) > 0) begin
            if (line.len() > 0 && line[0] != "#") begin
                got = $sscanf(line, "%d %d %d %d %d %d %d %d %d",
                              v[0], v[1], v[2], v[3], v[4], v[5], v[6], v[7], v[8]);
                if (got == 9 && n_cmd < MAX_CMD) begin
                    for (int j = 0; j < 9; j++) cmd_tab[n_cmd][j] = v[j];
                    n_cmd++;
                end
            end
        end
        $fclose(fd);
        assert (n_cmd > 0) else stop_with_error("no command found in tri_edges_stim.txt");
    endtask

    task automatic check_pixel;
        logic [19:0] want;
        if (psrc_o == render_pkg::SRC_AB) begin
            assert (exp_ab.size() > 0) else stop_with_error("extra pixel on edge AB");
            want = exp_ab.pop_front();
            n_ab++;
        end else begin
            assert (exp_ac.size() > 0) else stop_with_error("extra pixel on edge AC");
            want = exp_ac.pop_front();
            n_ac++;
        end
        assert (px_o == want[19:10]) else stop_with_error($sformatf(
            "ERROR px_o got %h expected %h (psrc_o %h)", px_o, want[19:10], psrc_o));
        assert (py_o == want[9:0]) else stop_with_error($sformatf(
            "ERROR py_o got %h expected %h (psrc_o %h)", py_o, want[9:0], psrc_o));
    endtask

    // output monitor, samples away from the active edge
    always @(negedge clk) begin
        if (!reset_i) begin
            assert (!(pvalid_o && stall_prev)) else stop_with_error($sformatf(
                "ERROR pvalid_o got %h expected %h after stall", pvalid_o, 1'b0));
            if (pvalid_o) check_pixel();
            if (done_o) done_total++;
        end
        stall_prev = stall_i;
    end

    always @(posedge clk) begin
        #1;
        if (stall_en) stall_i = ($urandom % 4 == 0); // about one cycle in four
        else stall_i = 1'b0;
    end

    initial begin
        wait (cycle_limit > 0);
        forever begin
            @(posedge clk);
            cycle_cnt++;
            assert (cycle_cnt < cycle_limit) else stop_with_error($sformatf(
                "timeout, no end of the test after %0d cycles", cycle_cnt));
        end
    end

    task automatic wait_done;
        bit seen;
        seen = 1'b0;
        while (!seen) begin
            @(negedge clk);
            if (done_o) seen = 1'b1;
            else assert (busy_o) else stop_with_error("busy_o fell before done_o");
        end
    endtask

    // second start while busy, once one edge is idle and the other has points left
    task automatic start_when_one_edge_done(input int idx);
        bit sent;
        bit ab_idle;
        bit ac_idle;
        sent = 1'b0;
        while (!sent && busy_o) begin
            ab_idle = (n_ab == cmd_tab[idx][6]) && (cmd_tab[idx][7] - n_ac >= 2);
            ac_idle = (n_ac == cmd_tab[idx][7]) && (cmd_tab[idx][6] - n_ab >= 2);
            if (ab_idle || ac_idle) begin
                start_i = 1'b1;               // must be ignored
                @(posedge clk);
                #1;
                start_i = 1'b0;
                sent    = 1'b1;
            end else begin
                @(posedge clk);
                #1;
            end
        end
    endtask

    task automatic drive_vertices(input int idx);
        ax_i = geom_pkg::coord_t'(cmd_tab[idx][0]);
        ay_i = geom_pkg::coord_t'(cmd_tab[idx][1]);
        bx_i = geom_pkg::coord_t'(cmd_tab[idx][2]);
        by_i = geom_pkg::coord_t'(cmd_tab[idx][3]);
        cx_i = geom_pkg::coord_t'(cmd_tab[idx][4]);
        cy_i = geom_pkg::coord_t'(cmd_tab[idx][5]);
    endtask

    task automatic build_expect(input int idx);
        exp_ab.delete();
        exp_ac.delete();
        model_edge(cmd_tab[idx][0], cmd_tab[idx][1], cmd_tab[idx][2], cmd_tab[idx][3], 1'b0);
        model_edge(cmd_tab[idx][0], cmd_tab[idx][1], cmd_tab[idx][4], cmd_tab[idx][5], 1'b1);
        assert (exp_ab.size() == cmd_tab[idx][6]) else stop_with_error($sformatf(
            "line model and stim file disagree on edge AB of command %0d", idx));
        assert (exp_ac.size() == cmd_tab[idx][7]) else stop_with_error($sformatf(
            "line model and stim file disagree on edge AC of command %0d", idx));
        n_ab = 0;
        n_ac = 0;
    endtask

    task automatic run_command(input int idx);
        build_expect(idx);
        @(posedge clk);
        #1;
        drive_vertices(idx);
        stall_en = cmd_tab[idx][8][0];
        start_i  = 1'b1;
        @(posedge clk);
        #1;
        start_i = 1'b0;
        done_want++;
        start_when_one_edge_done(idx);
        wait_done();
        @(negedge clk);
        assert (!done_o) else stop_with_error($sformatf(
            "ERROR done_o got %h expected %h", done_o, 1'b0));
        assert (!busy_o) else stop_with_error($sformatf(
            "ERROR busy_o got %h expected %h", busy_o, 1'b0));
        assert (n_ab == cmd_tab[idx][6]) else stop_with_error($sformatf(
            "ERROR pixel count psrc_o AB got %h expected %h", n_ab, cmd_tab[idx][6]));
        assert (n_ac == cmd_tab[idx][7]) else stop_with_error($sformatf(
            "ERROR pixel count psrc_o AC got %h expected %h", n_ac, cmd_tab[idx][7]));
        assert (done_total == done_want) else stop_with_error($sformatf(
            "ERROR done_o pulses got %h expected %h", done_total, done_want));
        stall_en = 1'b0;
    endtask

    // reset in the middle of a line, then the same command again
    task automatic abort_and_rerun(input int idx);
        build_expect(idx);
        @(posedge clk);
        #1;
        drive_vertices(idx);
        start_i = 1'b1;
        @(posedge clk);
        #1;
        start_i = 1'b0;
        repeat (20) @(posedge clk);
        #1;
        reset_i = 1'b1;
        exp_ab.delete();
        exp_ac.delete();
        repeat (RESET_CYCLES) @(posedge clk);
        #1;
        reset_i = 1'b0;
        repeat (6) begin
            @(negedge clk);
            assert (!busy_o && !done_o && !pvalid_o) else stop_with_error($sformatf(
                "ERROR busy_o %h done_o %h pvalid_o %h after reset, expected 0",
                busy_o, done_o, pvalid_o));
        end
        run_command(idx);
    endtask

    initial begin
        int longest;
        int big_idx;
        int big_len;
        int limit;
        reset_i     = 1'b1;
        start_i     = 1'b0;
        stall_i     = 1'b0;
        ax_i        = '0;
        ay_i        = '0;
        bx_i        = '0;
        by_i        = '0;
        cx_i        = '0;
        cy_i        = '0;
        stall_en    = 1'b0;
        stall_prev  = 1'b0;
        done_total  = 0;
        done_want   = 0;
        cycle_cnt   = 0;
        cycle_limit = 0;
        void'($urandom(32'h9c03_c823));
        load_commands();
        limit   = 0;
        big_idx = 0;
        big_len = 0;
        for (int i = 0; i < n_cmd; i++) begin
            longest = (cmd_tab[i][6] > cmd_tab[i][7]) ? cmd_tab[i][6] : cmd_tab[i][7];
            limit   = limit + 8 * longest + 50;
            if (longest > big_len) begin
                big_len = longest;
                big_idx = i;
            end
        end
        cycle_limit = limit + 8 * big_len + 50; // aborted command runs twice
        repeat (RESET_CYCLES) @(posedge clk);
        #1;
        reset_i = 1'b0;
        for (int i = 0; i < n_cmd; i++) run_command(i);
        abort_and_rerun(big_idx);
        repeat (4) @(posedge clk);
        if (done_total == n_cmd + 1) begin
            $display("Everything OK");
            $finish;
        end else begin
            stop_with_error("not every command ended with exactly one done_o pulse");
        end
    end

endmodule

//--- tri_edges.sv
// triangle upper-edge renderer, two line engines feeding one pixel stream
`timescale 1ns/1ps

module tri_edges (
    input  logic                clk,
    input  logic                reset_i,
    input  logic                start_i,
    input  logic                stall_i,
    input  geom_pkg::coord_t    ax_i,
    input  geom_pkg::coord_t    ay_i,
    input  geom_pkg::coord_t    bx_i,
    input  geom_pkg::coord_t    by_i,
    input  geom_pkg::coord_t    cx_i,
    input  geom_pkg::coord_t    cy_i,
    output geom_pkg::coord_t    px_o,
    output geom_pkg::coord_t    py_o,
    output render_pkg::eng_id_t psrc_o,
    output logic                pvalid_o,
    output logic                busy_o,
    output logic                done_o
);

    line_if ab_if ();                             // edge A to B
    line_if ac_if ();                             // edge A to C

    // a start during a running command must not restart a finished engine
    assign ab_if.start = start_i && !busy_o;
    assign ac_if.start = start_i && !busy_o;

    assign ab_if.p0 = '{x: ax_i, y: ay_i};        // both edges leave the top vertex
    assign ab_if.p1 = '{x: bx_i, y: by_i};
    assign ac_if.p0 = '{x: ax_i, y: ay_i};
    assign ac_if.p1 = '{x: cx_i, y: cy_i};

    draw_line i_eng_ab (
        .clk     (clk),
        .reset_i (reset_i),
        .lif     (ab_if)
    );

    draw_line i_eng_ac (
        .clk     (clk),
        .reset_i (reset_i),
        .lif     (ac_if)
    );

    pixel_merge i_merge (
        .clk      (clk),
        .reset_i  (reset_i),
        .start_i  (start_i),
        .stall_i  (stall_i),
        .ab       (ab_if),
        .ac       (ac_if),
        .px_o     (px_o),
        .py_o     (py_o),
        .psrc_o   (psrc_o),
        .pvalid_o (pvalid_o),
        .busy_o   (busy_o),
        .done_o   (done_o)
    );

endmodule

//--- tri_edges_props.sv
// protocol properties on the triangle edge renderer ports
`timescale 1ns/1ps

module tri_edges_props (
    input logic clk,
    input logic reset_i,
    input logic start_i,
    input logic stall_i,
    input logic pvalid_o,
    input logic busy_o,
    input logic done_o
);

    // a stalled cycle hands no point over
    no_pixel_after_stall: assert property (
        @(posedge clk) disable iff (reset_i)
        stall_i |=> !pvalid_o
    ) else $error("pvalid_o high in the cycle after a stalled cycle");

    // single pulse, command is over
    done_single_pulse: assert property (
        @(posedge clk) disable iff (reset_i)
        done_o |=> (!done_o && !busy_o)
    ) else $error("done_o longer than one cycle or busy_o still high after it");

    busy_needs_start: assert property (
        @(posedge clk) disable iff (reset_i)
        $rose(busy_o) |-> $past(start_i)
    ) else $error("busy_o rose without start_i in the cycle before");

    // no disable here, reset itself is checked
    reset_clears_outputs: assert property (
        @(posedge clk)
        reset_i |=> (!pvalid_o && !busy_o && !done_o)
    ) else $error("reset did not clear pvalid_o, busy_o and done_o");

endmodule

bind tri_edges tri_edges_props i_props (.*);

//--- tri_edges_stim.txt
# one command per line, decimal: ax ay bx by cx cy n_ab n_ac stall
# n_ab and n_ac are pixel counts of the edges, stall 1 means random stall_i
100 50 60 90 140 90 41 41 0
100 50 60 90 140 90 41 41 1
200 10 190 60 205 70 51 61 0
200 10 150 20 260 25 51 61 1
50 50 50 80 50 90 31 41 0
50 50 10 50 90 50 41 41 1
300 300 300 300 310 305 1 11 0
300 300 300 300 300 300 1 1 0
300 300 300 300 300 300 1 1 1
0 0 0 0 20 7 1 21 1
120 40 119 41 121 41 2 2 0
120 40 119 41 121 41 2 2 1
400 100 340 130 460 200 61 101 0
400 100 340 130 460 200 61 101 1
10 5 3 40 255 6 36 246 0
250 0 0 250 500 250 251 251 1
256 128 255 200 257 129 73 2 0
64 64 64 65 65 64 2 2 1
64 64 63 64 64 64 2 1 0
80 20 20 27 140 27 61 61 1
80 20 79 120 81 120 101 101 0
80 20 79 120 81 120 101 101 1
500 500 480 511 511 511 21 12 0
5 5 0 10 10 10 6 6 1
30 200 2 290 33 210 91 11 1
150 150 149 152 180 151 3 31 0
333 33 111 44 444 55 223 112 1
7 7 7 7 8 8 1 2 1
